//--- game_screen.f
game_pkg.sv
vga_timing.sv
click_decoder.sv
game_state_ctrl.sv
button_overlay.sv
game_screen_top.sv
tb_game_screen_sva.sv
tb_game_screen.sv

//--- Bender.yml
package:
  name: game_screen

sources:
  # Design sources in compile order.
  - files:
      - game_pkg.sv
      - vga_timing.sv
      - click_decoder.sv
      - game_state_ctrl.sv
      - button_overlay.sv
      - game_screen_top.sv

  # Testbench and bound assertions.
  - target: test
    files:
      - tb_game_screen_sva.sv
      - tb_game_screen.sv

//--- tb_game_screen.sv
`timescale 1ns/1ps

module tb_game_screen;
    import game_pkg::*;

    localparam int BTN_W          = 125;
    localparam int BTN_H          = 75;
    localparam int CLICK_COOLDOWN = 20;
    localparam int BTN_X          = (HOR_PIXELS - BTN_W) / 2;
    localparam int BTN_Y          = (VER_PIXELS - BTN_H) / 3;
    localparam int FRAME          = HOR_TOTAL * VER_TOTAL;
    localparam int WATCHDOG       = 4 * FRAME + FRAME / 2;

    logic        clk = 1'b0;
    logic        rst;
    logic [1:0]  char_class;
    logic [11:0] mouse_x;
    logic [11:0] mouse_y;
    logic        mouse_left;
    logic        game_over;
    logic        hsync;
    logic        vsync;
    logic [11:0] rgb;
    state_t      state;
    logic        game_start;
    logic        back_to_menu;

    string       test_name = "reset";
    logic [31:0] rnd_state = 32'd69922;
    int          start_count = 0;
    int          back_count = 0;
    int          vsync_rises = 0;
    int          px = 0;
    int          py = 0;
    int          h_gap = 0;
    int          v_gap = 0;
    bit          h_seen = 1'b0;
    bit          v_seen = 1'b0;
    logic        hsync_d = 1'b0;
    logic        vsync_d = 1'b0;
    state_t      st_d = ST_MENU;
    logic [11:0] exp_rgb;

    game_screen_top UUT (
        .clk          (clk),
        .rst          (rst),
        .char_class   (char_class),
        .mouse_x      (mouse_x),
        .mouse_y      (mouse_y),
        .mouse_left   (mouse_left),
        .game_over    (game_over),
        .hsync        (hsync),
        .vsync        (vsync),
        .rgb          (rgb),
        .state        (state),
        .game_start   (game_start),
        .back_to_menu (back_to_menu)
    );

    bind game_screen_top tb_game_screen_sva #(
        .CLICK_COOLDOWN (CLICK_COOLDOWN)
    ) sva_checks (
        .clk          (clk),
        .rst          (rst),
        .game_start   (game_start),
        .back_to_menu (back_to_menu),
        .game_over    (game_over),
        .state        (state),
        .hblnk        (hblnk),
        .vblnk        (vblnk),
        .rgb          (rgb)
    );

    always #10 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_failure(input string text);
        $display("%s", text);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("error: %s expected %0d (0x%0h) actual %0d (0x%0h)",
                 name, expected, expected, actual, actual);
        abort_run();
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_rand(input int range, output int val);
        rnd_state = xorshift(rnd_state);
        val = int'(rnd_state % 32'(range));
    endtask

    // Expected colour of one pixel from its distance to the nearest button edges.
    function automatic logic [11:0] expected_pixel(input int x, input int y, input state_t st);
        int          dx;
        int          dy;
        logic [11:0] colour;
        dx = (x - BTN_X < BTN_X + BTN_W - 1 - x) ? x - BTN_X : BTN_X + BTN_W - 1 - x;
        dy = (y - BTN_Y < BTN_Y + BTN_H - 1 - y) ? y - BTN_Y : BTN_Y + BTN_H - 1 - y;
        if (x >= HOR_PIXELS || y >= VER_PIXELS) begin
            colour = 12'h000;
        end else if (st == ST_PLAYING || dx < 0 || dy < 0) begin
            colour = BG_COLOR;
        end else if (dx < 4 && dy < 4) begin
            colour = BG_COLOR;
        end else if (dx < 2 || dy < 2) begin
            colour = BORDER_COLOR;
        end else begin
            colour = (st == ST_MENU) ? START_FILL : AGAIN_FILL;
        end
        return colour;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_vsync_rises(input int count);
        int target;
        int cycles;
        target = vsync_rises + count;
        cycles = 0;
        while (vsync_rises < target) begin
            @(negedge clk);
            cycles++;
            assert (cycles <= count * FRAME + 10)
                else report_failure("vsync stopped rising");
        end
    endtask

    // Drives a one-cycle click and returns on the falling edge after the sampling edge.
    task automatic click_at(input int x, input int y);
        mouse_x    = x[11:0];
        mouse_y    = y[11:0];
        mouse_left = 1'b1;
        @(negedge clk);
        mouse_left = 1'b0;
    endtask

    // Side 0 lies on the button, sides 1 to 4 lie above, below, left and right of it.
    task automatic pick_position(input int side, output int x, output int y);
        int dx;
        int dy;
        draw_rand(BTN_W, dx);
        draw_rand(BTN_H, dy);
        x = BTN_X + dx;
        y = BTN_Y + dy;
        case (side)
            1: begin
                y = dy % BTN_Y;
            end
            2: begin
                y = BTN_Y + BTN_H + dy;
            end
            3: begin
                x = dx % BTN_X;
            end
            4: begin
                x = BTN_X + BTN_W + dx;
            end
            default: begin
            end
        endcase
    endtask

    task automatic random_clicks(input int cycles, input bit allow_inside);
        int elapsed;
        int gap;
        int r;
        int side;
        int x;
        int y;
        elapsed = 0;
        while (elapsed < cycles) begin
            draw_rand(40, gap);
            wait_cycles(gap + 1);
            draw_rand(4, r);
            draw_rand(4, side);
            if (allow_inside) begin
                char_class = r[1:0];
            end
            pick_position((allow_inside && r[0]) ? 0 : side + 1, x, y);
            click_at(x, y);
            elapsed = elapsed + gap + 2;
        end
    endtask

    task automatic wait_pulse(input bit on_start, input int limit, output int waited);
        waited = 0;
        while (!(on_start ? game_start : back_to_menu)) begin
            @(negedge clk);
            waited++;
            assert (waited <= limit)
                else report_failure($sformatf("no pulse arrived in test %s", test_name));
        end
    endtask

    // ========================================
    // Pixel tracking and monitors
    // ========================================

    always @(negedge clk) begin
        if (UUT.sva_checks.fail_count != 0) begin
            report_failure($sformatf("a bound assertion failed in test %s", test_name));
        end
        if (!rst) begin
            h_gap++;
            v_gap++;
            px++;
            if (px == HOR_TOTAL) begin
                px = 0;
                py = (py + 1) % VER_TOTAL;
            end
            // The delayed hsync rises on pixel HSYNC_START, vsync on line VSYNC_START.
            if (hsync && !hsync_d) begin
                if (h_seen) begin
                    assert (h_gap == HOR_TOTAL)
                        else report_mismatch("hsync_period", HOR_TOTAL, h_gap);
                end
                h_seen = 1'b1;
                h_gap  = 0;
                px     = HSYNC_START;
            end
            if (vsync && !vsync_d) begin
                if (v_seen) begin
                    assert (v_gap == FRAME)
                        else report_mismatch("vsync_period", FRAME, v_gap);
                end
                v_seen = 1'b1;
                v_gap  = 0;
                py     = VSYNC_START;
                vsync_rises++;
            end
            if (h_seen && v_seen) begin
                exp_rgb = expected_pixel(px, py, st_d);
                assert (rgb == exp_rgb)
                    else report_mismatch($sformatf("%s pixel %0d,%0d", test_name, px, py),
                                         exp_rgb, rgb);
            end
            assert (!((game_start || back_to_menu) && st_d == ST_PLAYING))
                else report_failure("a click pulse appeared while playing");
            if (game_start) begin
                start_count++;
            end
            if (back_to_menu) begin
                back_count++;
            end
        end
        hsync_d = hsync;
        vsync_d = vsync;
        st_d    = state;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        report_failure($sformatf("watchdog expired during test %s", test_name));
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        int x;
        int y;
        int waited;
        rst        = 1'b1;
        char_class = 2'd0;
        mouse_x    = '0;
        mouse_y    = '0;
        mouse_left = 1'b0;
        game_over  = 1'b0;
        wait_cycles(16);
        rst = 1'b0;

        // Two vsync edges give one full frame of the menu screen.
        test_name = "timing";
        wait_vsync_rises(2);

        test_name = "menu_ignore_game_over";
        game_over = 1'b1;
        wait_cycles(1);
        game_over = 1'b0;
        wait_cycles(2);
        assert (state == ST_MENU) else report_mismatch(test_name, ST_MENU, int'(state));

        test_name = "menu_no_class";
        pick_position(0, x, y);
        click_at(x, y);
        wait_cycles(3);
        assert (start_count == 0) else report_mismatch(test_name, 0, start_count);

        test_name = "menu_outside";
        char_class = 2'd1;
        for (int i = 0; i < 8; i++) begin
            pick_position(i % 4 + 1, x, y);
            draw_rand(10, waited);
            wait_cycles(waited + 1);
            click_at(x, y);
        end
        // Pixels just outside each edge of the button.
        click_at(BTN_X - 1, BTN_Y);
        wait_cycles(1);
        click_at(BTN_X + BTN_W, BTN_Y + BTN_H - 1);
        wait_cycles(1);
        click_at(BTN_X, BTN_Y - 1);
        wait_cycles(1);
        click_at(BTN_X + BTN_W - 1, BTN_Y + BTN_H);
        wait_cycles(3);
        assert (start_count == 0) else report_mismatch(test_name, 0, start_count);

        test_name = "menu_start";
        click_at(BTN_X + BTN_W - 1, BTN_Y + BTN_H - 1);
        assert (game_start == 1'b1) else report_mismatch(test_name, 1, game_start);
        assert (state == ST_MENU) else report_mismatch(test_name, ST_MENU, int'(state));
        wait_cycles(1);
        assert (state == ST_PLAYING) else report_mismatch(test_name, ST_PLAYING, int'(state));

        test_name = "playing_frame";
        random_clicks(FRAME, 1'b1);
        assert (state == ST_PLAYING) else report_mismatch(test_name, ST_PLAYING, int'(state));
        assert (start_count == 1) else report_mismatch(test_name, 1, start_count);

        test_name = "over_enter";
        game_over = 1'b1;
        wait_cycles(1);
        game_over = 1'b0;
        assert (state == ST_OVER) else report_mismatch(test_name, ST_OVER, int'(state));

        test_name = "over_frame";
        random_clicks(FRAME, 1'b0);
        assert (back_count == 0) else report_mismatch(test_name, 0, back_count);

        // A held click returns to the menu and starts again once the cooldown ends.
        test_name  = "cooldown";
        char_class = 2'd2;
        pick_position(0, x, y);
        mouse_x    = x[11:0];
        mouse_y    = y[11:0];
        mouse_left = 1'b1;
        wait_pulse(1'b0, 4, waited);
        wait_cycles(1);
        assert (state == ST_MENU) else report_mismatch(test_name, ST_MENU, int'(state));
        wait_pulse(1'b1, CLICK_COOLDOWN + 8, waited);
        assert (waited + 1 > CLICK_COOLDOWN)
            else report_mismatch(test_name, CLICK_COOLDOWN + 1, waited + 1);
        mouse_left = 1'b0;
        wait_cycles(2);
        assert (state == ST_PLAYING) else report_mismatch(test_name, ST_PLAYING, int'(state));
        assert (back_count == 1) else report_mismatch(test_name, 1, back_count);

        if (UUT.sva_checks.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_failure("a bound assertion failed");
        end
    end

endmodule

//--- tb_game_screen_sva.sv
`timescale 1ns/1ps

module tb_game_screen_sva #(
    parameter int CLICK_COOLDOWN = 20
) (
    input logic             clk,
    input logic             rst,
    input logic             game_start,
    input logic             back_to_menu,
    input logic             game_over,
    input game_pkg::state_t state,
    input logic             hblnk,
    input logic             vblnk,
    input logic [11:0]      rgb
);
    import game_pkg::*;

    int   fail_count = 0;
    int   since_pulse;
    logic pulse;

    assign pulse = game_start || back_to_menu;

    // Cycles since the last pulse, saturating just past the cooldown.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            since_pulse <= CLICK_COOLDOWN + 1;
        end else if (pulse) begin
            since_pulse <= 1;
        end else if (since_pulse <= CLICK_COOLDOWN) begin
            since_pulse <= since_pulse + 1;
        end
    end

    a_pulse_width: assert property (@(posedge clk) disable iff (rst) pulse |=> !pulse)
        else begin
            $error("click pulse lasted more than one cycle");
            fail_count++;
        end

    a_cooldown: assert property (@(posedge clk) disable iff (rst)
        pulse |-> (since_pulse > CLICK_COOLDOWN))
        else begin
            $error("click pulse inside the cooldown window");
            fail_count++;
        end

    a_transition: assert property (@(posedge clk) disable iff (rst)
        (state != $past(state)) |->
            (($past(state) == ST_MENU && state == ST_PLAYING && $past(game_start)) ||
             ($past(state) == ST_PLAYING && state == ST_OVER && $past(game_over)) ||
             ($past(state) == ST_OVER && state == ST_MENU && $past(back_to_menu))))
        else begin
            $error("illegal state transition");
            fail_count++;
        end

    // The overlay registers the colour, so blanking shows up one cycle later.
    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        (hblnk || vblnk) |=> (rgb == 12'h000))
        else begin
            $error("colour not black during blanking");
            fail_count++;
        end

endmodule

//--- game_screen_top.sv
`timescale 1ns/1ps

module game_screen_top #(
    parameter int BTN_W          = 125,
    parameter int BTN_H          = 75,
    parameter int CLICK_COOLDOWN = 20
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [1:0]               char_class,
    input  logic [game_pkg::CNT_W-1:0] mouse_x,
    input  logic [game_pkg::CNT_W-1:0] mouse_y,
    input  logic                     mouse_left,
    input  logic                     game_over,
    output logic                     hsync,
    output logic                     vsync,
    output logic [11:0]              rgb,
    output game_pkg::state_t         state,
    output logic                     game_start,
    output logic                     back_to_menu
);
    import game_pkg::*;

    // Raw timing, one cycle ahead of the colour.
    logic [CNT_W-1:0] hcount;
    logic [CNT_W-1:0] vcount;
    logic             hsync_raw;
    logic             vsync_raw;
    logic             hblnk;
    logic             vblnk;

    vga_timing u_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync_raw),
        .vsync  (vsync_raw),
        .hblnk  (hblnk),
        .vblnk  (vblnk)
    );

    click_decoder #(
        .BTN_W          (BTN_W),
        .BTN_H          (BTN_H),
        .CLICK_COOLDOWN (CLICK_COOLDOWN)
    ) u_click_decoder (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .char_class   (char_class),
        .mouse_x      (mouse_x),
        .mouse_y      (mouse_y),
        .mouse_left   (mouse_left),
        .game_start   (game_start),
        .back_to_menu (back_to_menu)
    );

    game_state_ctrl u_game_state_ctrl (
        .clk          (clk),
        .rst          (rst),
        .game_start   (game_start),
        .back_to_menu (back_to_menu),
        .game_over    (game_over),
        .state        (state)
    );

    button_overlay #(
        .BTN_W (BTN_W),
        .BTN_H (BTN_H)
    ) u_button_overlay (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .hcount   (hcount),
        .vcount   (vcount),
        .hsync_in (hsync_raw),
        .vsync_in (vsync_raw),
        .hblnk_in (hblnk),
        .vblnk_in (vblnk),
        .hsync    (hsync),
        .vsync    (vsync),
        .rgb      (rgb)
    );

endmodule

//--- button_overlay.sv
`timescale 1ns/1ps

module button_overlay #(
    parameter int BTN_W = 125,
    parameter int BTN_H = 75
) (
    input  logic                     clk,
    input  logic                     rst,
    input  game_pkg::state_t         state,
    input  logic [game_pkg::CNT_W-1:0] hcount,
    input  logic [game_pkg::CNT_W-1:0] vcount,
    input  logic                     hsync_in,
    input  logic                     vsync_in,
    input  logic                     hblnk_in,
    input  logic                     vblnk_in,
    output logic                     hsync,
    output logic                     vsync,
    output logic [11:0]              rgb
);
    import game_pkg::*;

    localparam int BTN_X  = (HOR_PIXELS - BTN_W) / 2;
    localparam int BTN_Y  = (VER_PIXELS - BTN_H) / 3;
    localparam int CORNER = 4;
    localparam int BORDER = 2;

    logic [CNT_W-1:0] rel_x;
    logic [CNT_W-1:0] rel_y;
    logic             in_rect;
    logic             show_btn;
    logic             corner_x;
    logic             corner_y;
    logic             edge_px;
    logic [11:0]      sprite;
    logic [11:0]      rgb_nxt;

    // ========================================
    // Button sprite
    // ========================================

    always_comb begin
        in_rect = (hcount >= BTN_X) && (hcount < BTN_X + BTN_W) &&
                  (vcount >= BTN_Y) && (vcount < BTN_Y + BTN_H);
        show_btn = (state == ST_MENU) || (state == ST_OVER);

        // Offsets are only meaningful inside the rectangle.
        rel_x = hcount - CNT_W'(BTN_X);
        rel_y = vcount - CNT_W'(BTN_Y);

        corner_x = (rel_x < CORNER) || (rel_x >= BTN_W - CORNER);
        corner_y = (rel_y < CORNER) || (rel_y >= BTN_H - CORNER);
        edge_px  = (rel_x < BORDER) || (rel_x >= BTN_W - BORDER) ||
                   (rel_y < BORDER) || (rel_y >= BTN_H - BORDER);

        // First matching rule wins: rounded corner, then border, then fill.
        if (!(in_rect && show_btn)) begin
            sprite = TRANSPARENT;
        end else if (corner_x && corner_y) begin
            sprite = TRANSPARENT;
        end else if (edge_px) begin
            sprite = BORDER_COLOR;
        end else if (state == ST_MENU) begin
            sprite = START_FILL;
        end else begin
            sprite = AGAIN_FILL;
        end
    end

    // ========================================
    // Colour mix and output register
    // ========================================

    always_comb begin
        rgb_nxt = BG_COLOR;
        if (sprite != TRANSPARENT) begin
            rgb_nxt = sprite;
        end
        if (hblnk_in || vblnk_in) begin
            rgb_nxt = '0;
        end
    end

    // The syncs take the same single register stage as the colour.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            rgb   <= '0;
        end else begin
            hsync <= hsync_in;
            vsync <= vsync_in;
            rgb   <= rgb_nxt;
        end
    end

endmodule

//--- game_state_ctrl.sv
`timescale 1ns/1ps

module game_state_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             game_start,
    input  logic             back_to_menu,
    input  logic             game_over,
    output game_pkg::state_t state
);
    import game_pkg::*;

    state_t state_nxt;

    // ========================================
    // Next state
    // ========================================

    // Each state listens to one event only; the others are dropped.
    always_comb begin
        state_nxt = state;
        case (state)
            ST_MENU: begin
                if (game_start) begin
                    state_nxt = ST_PLAYING;
                end
            end
            ST_PLAYING: begin
                if (game_over) begin
                    state_nxt = ST_OVER;
                end
            end
            ST_OVER: begin
                if (back_to_menu) begin
                    state_nxt = ST_MENU;
                end
            end
            default: begin
                // Unused encoding, recover to the menu.
                state_nxt = ST_MENU;
            end
        endcase
    end

    // ========================================
    // State register
    // ========================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_MENU;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

//--- click_decoder.sv
`timescale 1ns/1ps

module click_decoder #(
    parameter int BTN_W          = 125,
    parameter int BTN_H          = 75,
    parameter int CLICK_COOLDOWN = 20
) (
    input  logic                     clk,
    input  logic                     rst,
    input  game_pkg::state_t         state,
    input  logic [1:0]               char_class,
    input  logic [game_pkg::CNT_W-1:0] mouse_x,
    input  logic [game_pkg::CNT_W-1:0] mouse_y,
    input  logic                     mouse_left,
    output logic                     game_start,
    output logic                     back_to_menu
);
    import game_pkg::*;

    localparam int BTN_X = (HOR_PIXELS - BTN_W) / 2;
    localparam int BTN_Y = (VER_PIXELS - BTN_H) / 3;
    localparam int CD_W  = (CLICK_COOLDOWN > 0) ? $clog2(CLICK_COOLDOWN + 1) : 1;

    logic [CD_W-1:0] cooldown;
    logic            on_button;
    logic            click_ok;
    logic            fire_start;
    logic            fire_back;

    // ========================================
    // Click qualification
    // ========================================

    always_comb begin
        on_button = (mouse_x >= BTN_X) && (mouse_x < BTN_X + BTN_W) &&
                    (mouse_y >= BTN_Y) && (mouse_y < BTN_Y + BTN_H);
        click_ok  = mouse_left && on_button && (cooldown == '0);

        // The start button only counts once a character has been chosen.
        fire_start = click_ok && (state == ST_MENU) && (char_class != 2'd0);
        fire_back  = click_ok && (state == ST_OVER);
    end

    // ========================================
    // Pulses and cooldown
    // ========================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_start   <= 1'b0;
            back_to_menu <= 1'b0;
            cooldown     <= '0;
        end else begin
            game_start   <= fire_start;
            back_to_menu <= fire_back;
            if (fire_start || fire_back) begin
                cooldown <= CD_W'(CLICK_COOLDOWN);
            end else if (cooldown != '0) begin
                cooldown <= cooldown - 1'b1;
            end
        end
    end

endmodule

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic                     clk,
    input  logic                     rst,
    output logic [game_pkg::CNT_W-1:0] hcount,
    output logic [game_pkg::CNT_W-1:0] vcount,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     hblnk,
    output logic                     vblnk
);
    import game_pkg::*;

    logic h_wrap;
    logic v_wrap;

    // ========================================
    // Pixel and line counters
    // ========================================

    assign h_wrap = (hcount == HOR_TOTAL - 1);
    assign v_wrap = (vcount == VER_TOTAL - 1);

    // The horizontal counter runs every cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= '0;
        end else if (h_wrap) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // A new line starts on each horizontal wrap.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vcount <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    // ========================================
    // Sync and blanking
    // ========================================

    // Both follow the counters directly, so they line up with hcount and vcount.
    always_comb begin
        hblnk = (hcount >= HOR_PIXELS);
        vblnk = (vcount >= VER_PIXELS);
        hsync = (hcount >= HSYNC_START) && (hcount < HSYNC_END);
        vsync = (vcount >= VSYNC_START) && (vcount < VSYNC_END);
    end

endmodule

//--- game_pkg.sv
package game_pkg;

    // ========================================
    // Screen geometry
    // ========================================

    // Visible area of the 640x480 mode and the width of the pixel counters.
    localparam int CNT_W      = 12;
    localparam int HOR_PIXELS = 640;
    localparam int VER_PIXELS = 480;

    // Full frame including the porches and the sync pulses.
    localparam int HOR_TOTAL = 800;
    localparam int VER_TOTAL = 525;

    // Sync pulses are active high in [start, end).
    localparam int HSYNC_START = 656;
    localparam int HSYNC_END   = 752;
    localparam int VSYNC_START = 490;
    localparam int VSYNC_END   = 492;

    // ========================================
    // Screen state
    // ========================================

    typedef enum logic [1:0] {
        ST_MENU    = 2'd0,
        ST_PLAYING = 2'd1,
        ST_OVER    = 2'd2
    } state_t;

    // ========================================
    // Colours, 4 bits per channel as RGB
    // ========================================

    localparam logic [11:0] BG_COLOR     = 12'h124;
    localparam logic [11:0] BORDER_COLOR = 12'hFFF;
    localparam logic [11:0] START_FILL   = 12'h0C0;
    localparam logic [11:0] AGAIN_FILL   = 12'hC00;

    // Sprite pixels of this value let the background show through.
    localparam logic [11:0] TRANSPARENT  = 12'h000;

endpackage
